/* project.f */
design/kernel_pkg.sv
design/kernel_control.sv
design/wb_descriptor_regs.sv
design/descriptor_decode.sv
design/cluster_execute.sv
design/result_merge.sv
design/kernel_top.sv
sim/kernel_assertions.sv
sim/kernel_tb.sv

/* Makefile */
BIN := obj_dir/Vkernel_tb

.PHONY: all run check clean

all: check

# Rebuilt only when a source or the file list changes
$(BIN): project.f $(wildcard design/*.sv sim/*.sv)
	verilator --binary --assert -Wno-fatal --top-module kernel_tb -f project.f

run: $(BIN)
	./$(BIN) > sim.log 2>&1 || true
	cat sim.log
	grep -q "STATUS: PASS" sim.log

check: run
	@echo "Simulation log shows a pass"

clean:
	rm -rf obj_dir sim.log

/* sim/kernel_tb.sv */
`timescale 1ns/1ps

module kernel_tb
    import kernel_pkg::*;
();

    localparam int NUM_CLUSTERS = 4;
    localparam int ACK_LIMIT    = 16;
    localparam int POLL_LIMIT   = 100;

    typedef struct packed {
        kernel_opcode_e opcode;
        logic [31:0]    base;
        logic [15:0]    count;
        logic [31:0]    got;
    } run_record_t;

    logic                  ap_clk;
    logic                  control_areset;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic [2:0]            wb_adr;
    logic [DATA_WIDTH-1:0] wb_dat_w;
    logic [DATA_WIDTH-1:0] wb_dat_r;
    logic                  wb_ack;

    // Results waiting for the compare process
    run_record_t runs_q [$];
    int          errors   = 0;
    int          launched = 0;
    int          compared = 0;

    kernel_top #(.NUM_CLUSTERS(NUM_CLUSTERS)) u_dut (
        .ap_clk         (ap_clk),
        .control_areset (control_areset),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_dat_w       (wb_dat_w),
        .wb_dat_r       (wb_dat_r),
        .wb_ack         (wb_ack)
    );

    initial begin
        ap_clk = 1'b0;
        forever #5 ap_clk = ~ap_clk;
    end

    // ------------------------------------------------
    // Reference model and checks
    // ------------------------------------------------
    function automatic logic [31:0] reduce_expected(input kernel_opcode_e op,
                                                    input logic [31:0] base,
                                                    input logic [15:0] count);
        logic [31:0] acc;
        logic [31:0] id;
        int          n;
        acc = '0;
        n   = int'(count);
        // Ids base .. base+count-1, wrapping mod 2^32
        for (int i = 0; i < n; i++) begin
            id = base + 32'(i);
            case (op)
                OP_XOR:       acc = acc ^ id;
                OP_ODD_COUNT: acc = acc + {31'd0, id[0]};
                default:      acc = acc + id;
            endcase
        end
        return acc;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            errors++;
            $display("ERR t=%0t %s got 0x%08h expected 0x%08h", $time, name, got, expected);
            $display("STATUS: FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t while waiting for %s", $time, what);
        $display("STATUS: FAIL");
        $fatal(1, "stopped on timeout");
    endtask

    // ------------------------------------------------
    // Wishbone master
    // ------------------------------------------------
    task automatic bus_access(input logic we, input logic [2:0] adr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int cycles;
        cycles = 0;
        @(posedge ap_clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdata;
        // Held until ack shows up
        do begin
            @(posedge ap_clk);
            cycles++;
            if (cycles > ACK_LIMIT) report_timeout("wb_ack");
        end while (!wb_ack);
        rdata = wb_dat_r;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        // Ack must drop after one cycle
        @(posedge ap_clk);
        check_value("wb_ack", {31'd0, wb_ack}, 32'd0);
    endtask

    task automatic bus_write(input logic [2:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        bus_access(1'b1, adr, data, unused);
    endtask

    task automatic bus_read(input logic [2:0] adr, output logic [31:0] data);
        bus_access(1'b0, adr, 32'd0, data);
    endtask

    // ------------------------------------------------
    // Kernel runs
    // ------------------------------------------------
    task automatic program_descriptor(input kernel_opcode_e op, input logic [31:0] base,
                                      input logic [15:0] count);
        bus_write(REG_OPCODE, {30'd0, op});
        bus_write(REG_BASE, base);
        bus_write(REG_COUNT, {16'd0, count});
    endtask

    task automatic wait_for_done();
        logic [31:0] status;
        int          polls;
        polls = 0;
        // Done from the previous run may still be showing
        do begin
            bus_read(REG_STATUS, status);
            polls++;
            if (polls > POLL_LIMIT) report_timeout("done to clear");
        end while (status[2]);
        polls = 0;
        do begin
            bus_read(REG_STATUS, status);
            polls++;
            if (polls > POLL_LIMIT) report_timeout("done to be set");
        end while (!status[2]);
    endtask

    task automatic collect_result(input kernel_opcode_e op, input logic [31:0] base,
                                  input logic [15:0] count);
        logic [31:0] rdata;
        bus_read(REG_RESULT, rdata);
        runs_q.push_back('{opcode: op, base: base, count: count, got: rdata});
        launched++;
    endtask

    // ctrl bit 0 is start, bit 1 is continue
    task automatic run_kernel(input kernel_opcode_e op, input logic [31:0] base,
                              input logic [15:0] count, input logic [1:0] ctrl);
        program_descriptor(op, base, count);
        bus_write(REG_CTRL, {30'd0, ctrl});
        wait_for_done();
        collect_result(op, base, count);
    endtask

    // ------------------------------------------------
    // Compare process
    // ------------------------------------------------
    initial begin : compare_results
        run_record_t rec;
        logic [31:0] expected;
        forever begin
            @(posedge ap_clk);
            while (runs_q.size() > 0) begin
                rec      = runs_q.pop_front();
                expected = reduce_expected(rec.opcode, rec.base, rec.count);
                check_value("REG_RESULT", rec.got, expected);
                compared++;
            end
        end
    end

    // ------------------------------------------------
    // Stimulus
    // ------------------------------------------------
    initial begin : stimulus
        kernel_opcode_e ops [3];
        logic [31:0]    rdata;
        logic [31:0]    base;
        logic [15:0]    count;
        int             polls;

        ops = '{OP_SUM, OP_XOR, OP_ODD_COUNT};
        void'($urandom(32'h339ceb4d));
        control_areset = 1'b1;
        wb_cyc         = 1'b0;
        wb_stb         = 1'b0;
        wb_we          = 1'b0;
        wb_adr         = 3'd0;
        wb_dat_w       = 32'd0;
        repeat (10) @(posedge ap_clk);
        control_areset <= 1'b0;

        // Reset status and register readback
        bus_read(REG_STATUS, rdata);
        check_value("REG_STATUS", rdata, 32'h1);
        program_descriptor(OP_XOR, 32'hdead_0010, 16'd37);
        bus_read(REG_OPCODE, rdata);
        check_value("REG_OPCODE", rdata, 32'(OP_XOR));
        bus_read(REG_BASE, rdata);
        check_value("REG_BASE", rdata, 32'hdead_0010);
        bus_read(REG_COUNT, rdata);
        check_value("REG_COUNT", rdata, 32'd37);

        // Hole in the map
        bus_write(3'd7, 32'hffff_ffff);
        bus_read(3'd7, rdata);
        check_value("unmapped 7", rdata, 32'd0);

        // Each opcode, random base and count
        foreach (ops[i]) begin
            base  = $urandom();
            count = 16'($urandom_range(40, 1));
            run_kernel(ops[i], base, count, 2'b01);
        end

        // Short slices, ending on an empty run
        for (int c = NUM_CLUSTERS - 1; c >= 0; c--) begin
            run_kernel(ops[c % 3], $urandom(), 16'(c), 2'b01);
        end
        bus_read(REG_RESULT, rdata);
        check_value("REG_RESULT count 0", rdata, 32'd0);

        // Continue from done with a new descriptor
        run_kernel(OP_ODD_COUNT, $urandom(), 16'd29, 2'b10);
        run_kernel(OP_SUM, $urandom(), 16'd29, 2'b10);

        // Long walk, wide busy window
        base = $urandom();
        program_descriptor(OP_SUM, base, 16'd200);
        bus_write(REG_CTRL, 32'h1);
        polls = 0;
        do begin
            bus_read(REG_STATUS, rdata);
            polls++;
            if (polls > POLL_LIMIT) report_timeout("the kernel to leave idle");
        end while (rdata[0]);
        bus_read(REG_STATUS, rdata);
        check_value("REG_STATUS.idle", {31'd0, rdata[0]}, 32'd0);
        check_value("REG_STATUS.done", {31'd0, rdata[2]}, 32'd0);
        // New base mid-run, so a restarted walk would give another sum
        bus_write(REG_BASE, ~base);
        // Start while busy, dropped by the FSM
        bus_write(REG_CTRL, 32'h1);
        wait_for_done();
        collect_result(OP_SUM, base, 16'd200);
        // Parked in done, no second run
        repeat (4) begin
            bus_read(REG_STATUS, rdata);
            check_value("REG_STATUS.done", {31'd0, rdata[2]}, 32'd1);
        end

        polls = 0;
        while (runs_q.size() != 0) begin
            @(posedge ap_clk);
            polls++;
            if (polls > ACK_LIMIT) report_timeout("the last result comparison");
        end

        if (errors == 0 && compared == launched) begin
            $display("STATUS: PASS");
        end else begin
            $display("Only %0d of %0d results were compared", compared, launched);
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* sim/kernel_assertions.sv */
`timescale 1ns/1ps

module kernel_assertions
    import kernel_pkg::*;
#(
    parameter bit BUS_SIDE = 1'b0
) (
    input logic         ap_clk,
    input logic         control_areset,
    input logic         ack,
    input control_out_t flags,
    input logic         desc_valid
);

    // ------------------------------------------------
    // Bus and handshake properties
    // ------------------------------------------------

    if (BUS_SIDE) begin : g_bus

        // Classic slave acks for a single cycle only
        ack_single_cycle: assert property (
            @(posedge ap_clk) disable iff (control_areset) ack |=> !ack
        ) else $error("wb_ack stayed high for two cycles");

        // Ready and done come from different states
        flags_exclusive: assert property (
            @(posedge ap_clk) disable iff (control_areset) !(flags.done && flags.ready)
        ) else $error("done and ready set in the same cycle");

    end else begin : g_control

        // No descriptor released while idle
        valid_not_idle: assert property (
            @(posedge ap_clk) disable iff (control_areset) flags.idle |-> !desc_valid
        ) else $error("descriptor valid while idle is set");

    end

endmodule

// Control side, no bus visible here
bind kernel_control kernel_assertions #(.BUS_SIDE(1'b0)) u_control_checks (
    .ap_clk         (ap_clk),
    .control_areset (control_areset),
    .ack            (1'b0),
    .flags          (control_out),
    .desc_valid     (descriptor_out.valid)
);

// Bus side, released descriptor not visible here
bind wb_descriptor_regs kernel_assertions #(.BUS_SIDE(1'b1)) u_bus_checks (
    .ap_clk         (ap_clk),
    .control_areset (control_areset),
    .ack            (wb_ack),
    .flags          (control_status),
    .desc_valid     (1'b0)
);

/* design/kernel_top.sv */
`timescale 1ns/1ps

module kernel_top
    import kernel_pkg::*;
#(
    parameter int NUM_CLUSTERS = 4
) (
    input  logic                  ap_clk,
    input  logic                  control_areset,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  logic [2:0]            wb_adr,
    input  logic [DATA_WIDTH-1:0] wb_dat_w,
    output logic [DATA_WIDTH-1:0] wb_dat_r,
    output logic                  wb_ack
);

    control_in_t             control_pulse;
    control_out_t            control_status;
    descriptor_port_t        host_descriptor;
    descriptor_port_t        released_descriptor;
    cluster_command_t        commands [NUM_CLUSTERS];
    logic [NUM_CLUSTERS-1:0] cu_done;
    logic [NUM_CLUSTERS-1:0] cu_setup;
    logic [DATA_WIDTH-1:0]   partials [NUM_CLUSTERS];
    logic [DATA_WIDTH-1:0]   result;

    // ------------------------------------------------
    // Host side
    // ------------------------------------------------
    wb_descriptor_regs u_regs (
        .ap_clk         (ap_clk),
        .control_areset (control_areset),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_dat_w       (wb_dat_w),
        .wb_dat_r       (wb_dat_r),
        .wb_ack         (wb_ack),
        .control_status (control_status),
        .result         (result),
        .control_pulse  (control_pulse),
        .descriptor     (host_descriptor)
    );

    kernel_control #(.NUM_CLUSTERS(NUM_CLUSTERS)) u_control (
        .ap_clk         (ap_clk),
        .control_areset (control_areset),
        .cu_done        (cu_done),
        .cu_setup       (cu_setup),
        .control_in     (control_pulse),
        .control_out    (control_status),
        .descriptor_in  (host_descriptor),
        .descriptor_out (released_descriptor)
    );

    // ------------------------------------------------
    // Compute side
    // ------------------------------------------------
    descriptor_decode #(.NUM_CLUSTERS(NUM_CLUSTERS)) u_decode (
        .ap_clk         (ap_clk),
        .control_areset (control_areset),
        .descriptor     (released_descriptor),
        .commands       (commands)
    );

    for (genvar k = 0; k < NUM_CLUSTERS; k++) begin : g_cluster
        cluster_execute u_cluster (
            .ap_clk         (ap_clk),
            .control_areset (control_areset),
            .command        (commands[k]),
            .cu_done        (cu_done[k]),
            .cu_setup       (cu_setup[k]),
            .partial        (partials[k])
        );
    end

    // Latched opcode stays put while the host edits the next descriptor
    result_merge #(.NUM_CLUSTERS(NUM_CLUSTERS)) u_merge (
        .ap_clk         (ap_clk),
        .control_areset (control_areset),
        .opcode         (commands[0].opcode),
        .partials       (partials),
        .result         (result)
    );

endmodule

/* design/result_merge.sv */
`timescale 1ns/1ps

module result_merge
    import kernel_pkg::*;
#(
    parameter int NUM_CLUSTERS = 4
) (
    input  logic                  ap_clk,
    input  logic                  control_areset,
    input  kernel_opcode_e        opcode,
    input  logic [DATA_WIDTH-1:0] partials [NUM_CLUSTERS],
    output logic [DATA_WIDTH-1:0] result
);

    logic [DATA_WIDTH-1:0] sum_all;
    logic [DATA_WIDTH-1:0] xor_all;

    // ------------------------------------------------
    // Combine across clusters
    // ------------------------------------------------
    always_comb begin
        sum_all = '0;
        xor_all = '0;
        for (int k = 0; k < NUM_CLUSTERS; k++) begin
            sum_all = sum_all + partials[k];
            xor_all = xor_all ^ partials[k];
        end
    end

    // Odd counts add up like sums
    always_ff @(posedge ap_clk) begin
        if (control_areset) begin
            result <= '0;
        end else begin
            case (opcode)
                OP_XOR:  result <= xor_all;
                default: result <= sum_all;
            endcase
        end
    end

endmodule

/* design/cluster_execute.sv */
`timescale 1ns/1ps

module cluster_execute
    import kernel_pkg::*;
(
    input  logic                  ap_clk,
    input  logic                  control_areset,
    input  cluster_command_t      command,
    output logic                  cu_done,
    output logic                  cu_setup,
    output logic [DATA_WIDTH-1:0] partial
);

    logic                  valid_q;
    logic                  walking;
    logic                  done_q;
    logic [31:0]           cur_id;
    logic [15:0]           remaining;
    logic [DATA_WIDTH-1:0] acc;
    logic [DATA_WIDTH-1:0] acc_next;
    logic                  launch;

    // Rising edge of valid starts a walk
    assign launch   = command.valid && !valid_q;
    assign cu_done  = done_q && command.valid;
    assign partial  = acc;

    // Reduction step for the current id
    always_comb begin
        case (command.opcode)
            OP_XOR:       acc_next = acc ^ cur_id;
            OP_ODD_COUNT: acc_next = acc + {{(DATA_WIDTH-1){1'b0}}, cur_id[0]};
            default:      acc_next = acc + cur_id;
        endcase
    end

    always_ff @(posedge ap_clk) begin
        if (control_areset) begin
            valid_q  <= 1'b0;
            walking  <= 1'b0;
            done_q   <= 1'b0;
            cu_setup <= 1'b1;
            acc      <= '0;
        end else begin
            valid_q  <= command.valid;
            // One cycle of setup after valid falls
            cu_setup <= valid_q && !command.valid;
            if (!command.valid) begin
                walking <= 1'b0;
                done_q  <= 1'b0;
            end else if (launch) begin
                acc     <= '0;
                walking <= (command.step_count != 16'd0);
                // Empty slice finishes with the identity
                done_q  <= (command.step_count == 16'd0);
            end else if (walking) begin
                acc <= acc_next;
                if (remaining == 16'd1) begin
                    walking <= 1'b0;
                    done_q  <= 1'b1;
                end
            end
        end
    end

    // Walk position
    always_ff @(posedge ap_clk) begin
        if (launch) begin
            cur_id    <= command.first_id;
            remaining <= command.step_count;
        end else if (walking) begin
            cur_id    <= cur_id + command.stride;
            remaining <= remaining - 16'd1;
        end
    end

endmodule

/* design/descriptor_decode.sv */
`timescale 1ns/1ps

module descriptor_decode
    import kernel_pkg::*;
#(
    parameter int NUM_CLUSTERS = 4
) (
    input  logic             ap_clk,
    input  logic             control_areset,
    input  descriptor_port_t descriptor,
    output cluster_command_t commands [NUM_CLUSTERS]
);

    logic             cmd_valid;
    kernel_opcode_e   opcode_q;
    logic [31:0]      first_id_q [NUM_CLUSTERS];
    logic [15:0]      step_q     [NUM_CLUSTERS];

    always_ff @(posedge ap_clk) begin
        if (control_areset) begin
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= descriptor.valid;
        end
    end

    // Latch once per release so host writes mid-run do not leak in
    always_ff @(posedge ap_clk) begin
        if (descriptor.valid && !cmd_valid) begin
            opcode_q <= descriptor.payload.opcode;
            for (int k = 0; k < NUM_CLUSTERS; k++) begin
                first_id_q[k] <= descriptor.payload.base + 32'(k);
                // Ids i in [0, count) with i mod N equal to k
                step_q[k] <= 16'((32'(descriptor.payload.count) + 32'(NUM_CLUSTERS - 1 - k))
                                 / 32'(NUM_CLUSTERS));
            end
        end
    end

    always_comb begin
        for (int k = 0; k < NUM_CLUSTERS; k++) begin
            commands[k].valid      = cmd_valid;
            commands[k].opcode     = opcode_q;
            commands[k].first_id   = first_id_q[k];
            commands[k].stride     = 32'(NUM_CLUSTERS);
            commands[k].step_count = step_q[k];
        end
    end

endmodule

/* design/wb_descriptor_regs.sv */
`timescale 1ns/1ps

module wb_descriptor_regs
    import kernel_pkg::*;
(
    input  logic                  ap_clk,
    input  logic                  control_areset,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  logic [2:0]            wb_adr,
    input  logic [DATA_WIDTH-1:0] wb_dat_w,
    output logic [DATA_WIDTH-1:0] wb_dat_r,
    output logic                  wb_ack,
    input  control_out_t          control_status,
    input  logic [DATA_WIDTH-1:0] result,
    output control_in_t           control_pulse,
    output descriptor_port_t      descriptor
);

    kernel_opcode_e opcode_q;
    logic [31:0]    base_q;
    logic [15:0]    count_q;
    logic           request;

    // New access seen, ack not yet given
    assign request = wb_cyc && wb_stb && !wb_ack;

    // Register contents always present
    assign descriptor.valid           = 1'b1;
    assign descriptor.payload.opcode  = opcode_q;
    assign descriptor.payload.base    = base_q;
    assign descriptor.payload.count   = count_q;

    // ------------------------------------------------
    // Ack, writes and control pulses
    // ------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (control_areset) begin
            wb_ack        <= 1'b0;
            control_pulse <= '0;
            opcode_q      <= OP_SUM;
            base_q        <= '0;
            count_q       <= '0;
        end else begin
            wb_ack        <= request;
            // Pulses last one cycle
            control_pulse <= '0;
            if (request && wb_we) begin
                case (wb_adr)
                    REG_CTRL: begin
                        control_pulse.start_pulse    <= wb_dat_w[0];
                        control_pulse.continue_pulse <= wb_dat_w[1];
                    end
                    REG_OPCODE: opcode_q <= kernel_opcode_e'(wb_dat_w[1:0]);
                    REG_BASE:   base_q   <= wb_dat_w;
                    REG_COUNT:  count_q  <= wb_dat_w[15:0];
                    default: ;
                endcase
            end
        end
    end

    // ------------------------------------------------
    // Read data, valid in the ack cycle
    // ------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (request) begin
            case (wb_adr)
                REG_STATUS: wb_dat_r <= {{(DATA_WIDTH-3){1'b0}}, control_status.done,
                                         control_status.ready, control_status.idle};
                REG_OPCODE: wb_dat_r <= {{(DATA_WIDTH-2){1'b0}}, opcode_q};
                REG_BASE:   wb_dat_r <= base_q;
                REG_COUNT:  wb_dat_r <= {{(DATA_WIDTH-16){1'b0}}, count_q};
                REG_RESULT: wb_dat_r <= result;
                // Control reads back zero, as do holes
                default:    wb_dat_r <= '0;
            endcase
        end
    end

endmodule

/* design/kernel_control.sv */
`timescale 1ns/1ps

module kernel_control
    import kernel_pkg::*;
#(
    parameter int NUM_CLUSTERS = 4
) (
    input  logic                    ap_clk,
    input  logic                    control_areset,
    input  logic [NUM_CLUSTERS-1:0] cu_done,
    input  logic [NUM_CLUSTERS-1:0] cu_setup,
    input  control_in_t             control_in,
    output control_out_t            control_out,
    input  descriptor_port_t        descriptor_in,
    output descriptor_port_t        descriptor_out
);

    logic [NUM_CLUSTERS-1:0] cu_done_reg;
    logic [NUM_CLUSTERS-1:0] cu_setup_reg;
    logic                    start_reg;
    logic                    continue_reg;

    control_state_e current_state;
    control_state_e next_state;

    // Flags from state, then two more stages to the port
    control_out_t flags_state;
    control_out_t flags_pipe;
    logic         descriptor_valid_state;

    // ------------------------------------------------
    // Input registers
    // ------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (control_areset) begin
            cu_done_reg  <= '0;
            // Clusters assumed busy clearing until told otherwise
            cu_setup_reg <= '1;
            start_reg    <= 1'b0;
            continue_reg <= 1'b0;
        end else begin
            cu_done_reg  <= cu_done;
            cu_setup_reg <= cu_setup;
            start_reg    <= control_in.start_pulse;
            continue_reg <= control_in.continue_pulse;
        end
    end

    // ------------------------------------------------
    // Output register stages
    // ------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (control_areset) begin
            flags_pipe  <= '{ready: 1'b0, done: 1'b0, idle: 1'b1};
            control_out <= '{ready: 1'b0, done: 1'b0, idle: 1'b1};
        end else begin
            flags_pipe  <= flags_state;
            control_out <= flags_pipe;
        end
    end

    // Valid gated by state, payload just follows the registers
    always_ff @(posedge ap_clk) begin
        if (control_areset) begin
            descriptor_out.valid <= 1'b0;
        end else begin
            descriptor_out.valid <= descriptor_valid_state && descriptor_in.valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        descriptor_out.payload <= descriptor_in.payload;
    end

    // ------------------------------------------------
    // Handshake FSM
    // ------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (control_areset) begin
            current_state <= CTRL_RESET;
        end else begin
            current_state <= next_state;
        end
    end

    always_comb begin
        next_state = current_state;
        case (current_state)
            CTRL_RESET: next_state = CTRL_IDLE;
            CTRL_IDLE:  next_state = CTRL_SETUP;
            // Hold until start and every cluster finished clearing
            CTRL_SETUP: if (start_reg && !(|cu_setup_reg)) next_state = CTRL_READY;
            CTRL_READY: next_state = CTRL_START;
            CTRL_START: next_state = CTRL_BUSY;
            // Start pulses ignored here
            CTRL_BUSY:  if (&cu_done_reg) next_state = CTRL_DONE;
            CTRL_DONE:  if (continue_reg || start_reg) next_state = CTRL_READY;
            default:    next_state = CTRL_RESET;
        endcase
    end

    // Flag decode, first register stage
    always_ff @(posedge ap_clk) begin
        if (control_areset) begin
            flags_state            <= '{ready: 1'b0, done: 1'b0, idle: 1'b1};
            descriptor_valid_state <= 1'b0;
        end else begin
            flags_state            <= '{ready: 1'b0, done: 1'b0, idle: 1'b0};
            descriptor_valid_state <= 1'b0;
            case (current_state)
                CTRL_READY: flags_state.ready <= 1'b1;
                CTRL_START,
                CTRL_BUSY:  descriptor_valid_state <= 1'b1;
                CTRL_DONE:  flags_state <= '{ready: 1'b0, done: 1'b1, idle: 1'b1};
                default:    flags_state.idle <= 1'b1;
            endcase
        end
    end

endmodule

/* design/kernel_pkg.sv */
package kernel_pkg;

    // ------------------------------------------------
    // Widths
    // ------------------------------------------------
    localparam int DATA_WIDTH = 32;

    // ------------------------------------------------
    // Opcodes and control states
    // ------------------------------------------------
    typedef enum logic [1:0] {
        OP_SUM       = 2'd0,
        OP_XOR       = 2'd1,
        OP_ODD_COUNT = 2'd2
    } kernel_opcode_e;

    // Same sequence as the ap_ctrl_hs handshake
    typedef enum logic [2:0] {
        CTRL_RESET = 3'd0,
        CTRL_IDLE  = 3'd1,
        CTRL_SETUP = 3'd2,
        CTRL_READY = 3'd3,
        CTRL_START = 3'd4,
        CTRL_BUSY  = 3'd5,
        CTRL_DONE  = 3'd6
    } control_state_e;

    // ------------------------------------------------
    // Descriptor and handshake structs
    // ------------------------------------------------
    typedef struct packed {
        kernel_opcode_e  opcode;
        logic [31:0]     base;
        logic [15:0]     count;
    } kernel_descriptor_t;

    typedef struct packed {
        logic               valid;
        kernel_descriptor_t payload;
    } descriptor_port_t;

    typedef struct packed {
        logic start_pulse;
        logic continue_pulse;
    } control_in_t;

    typedef struct packed {
        logic ready;
        logic done;
        logic idle;
    } control_out_t;

    // Per-cluster walk description
    typedef struct packed {
        logic            valid;
        kernel_opcode_e  opcode;
        logic [31:0]     first_id;
        logic [31:0]     stride;
        logic [15:0]     step_count;
    } cluster_command_t;

    // ------------------------------------------------
    // Register map, word addresses
    // ------------------------------------------------
    localparam logic [2:0] REG_CTRL   = 3'd0;
    localparam logic [2:0] REG_STATUS = 3'd1;
    localparam logic [2:0] REG_OPCODE = 3'd2;
    localparam logic [2:0] REG_BASE   = 3'd3;
    localparam logic [2:0] REG_COUNT  = 3'd4;
    localparam logic [2:0] REG_RESULT = 3'd5;

endpackage
